// ==== Makefile ====
# Verilator build and run of the byte stream output testbench

TOP   := axis_out_tb
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

// ==== src.f ====
verilog/axis_out_cfg_pkg.sv
verilog/axis_out_csr_pkg.sv
verilog/axis_out_wr_if.sv
verilog/axis_out_regs.sv
verilog/axis_out_fifo.sv
verilog/axis_out_stream.sv
verilog/axis_out_top.sv
verif/axis_out_tb.sv

// ==== verif/axis_out_tb.sv ====
// ==========================================================================
// table-driven testbench for the byte stream output block, runs CPU, DMA,
// padding, back-pressure, FIFO fill and soft reset cases against a model
// ==========================================================================

`default_nettype none

module axis_out_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import axis_out_cfg_pkg::*;
   import axis_out_csr_pkg::*;

   localparam int N_TESTS = 5;

   logic               clk;
   logic               rst_n;
   logic               csr_wen;
   csr_addr_t          csr_addr;
   logic [DATA_W-1:0]  csr_wdata;
   logic [3:0]         csr_wstrb;
   logic [DATA_W-1:0]  csr_rdata;
   logic               sys_tvalid;
   logic [DATA_W-1:0]  sys_tdata;
   logic               sys_tready;
   logic               tvalid;
   logic [TDATA_W-1:0] tdata;
   logic               tlast;
   logic               tready = 1'b0;
   logic               irq;

   // stimulus table, one entry per test
   string              t_name   [N_TESTS];
   mode_t              t_mode   [N_TESTS];
   int                 t_nbeats [N_TESTS];
   int                 t_thr    [N_TESTS];
   int                 t_nw     [N_TESTS];
   logic [DATA_W-1:0]  t_words  [N_TESTS][3];
   logic               t_rnd    [N_TESTS];
   logic               t_fill   [N_TESTS];

   integer             seed = 32'h3706_a135;
   logic [31:0]        rnd;
   int                 errors = 0;
   int                 stall_errors = 0;
   string              cur_name = "reset";
   // 0 always ready, 1 random, 2 held low
   int                 rdy_sel = 0;
   logic               mon_en = 1'b0;
   logic [TDATA_W:0]   got_q [$];
   logic               prev_stall = 1'b0;
   logic [TDATA_W:0]   prev_beat = '0;

   axis_out_top i_axis_out_top (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .csr_wen_i     (csr_wen),
      .csr_addr_i    (csr_addr),
      .csr_wdata_i   (csr_wdata),
      .csr_wstrb_i   (csr_wstrb),
      .csr_rdata_o   (csr_rdata),
      .sys_tvalid_i  (sys_tvalid),
      .sys_tdata_i   (sys_tdata),
      .sys_tready_o  (sys_tready),
      .axis_tvalid_o (tvalid),
      .axis_tdata_o  (tdata),
      .axis_tlast_o  (tlast),
      .axis_tready_i (tready),
      .interrupt_o   (irq)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      rnd = $random(seed);
      case (rdy_sel)
         0:       tready <= 1'b1;
         1:       tready <= rnd[0];
         default: tready <= 1'b0;
      endcase
   end

   // collects beats and checks data and last hold while stalled
   always @(posedge clk) begin
      if (mon_en) begin
         if (prev_stall && (!tvalid || ({tlast, tdata} != prev_beat))) begin
            $display("%s: stream output changed while stalled", cur_name);
            stall_errors++;
         end
         if (tvalid && tready) begin
            got_q.push_back({tlast, tdata});
         end
         prev_stall <= tvalid && !tready;
         prev_beat  <= {tlast, tdata};
      end else begin
         prev_stall <= 1'b0;
      end
   end

   task automatic add_test(input int idx, input string name, input mode_t mode,
                           input int nbeats, input int thr, input int nw,
                           input logic [DATA_W-1:0] w0, input logic [DATA_W-1:0] w1,
                           input logic [DATA_W-1:0] w2, input logic rnd_rdy,
                           input logic fill);
      t_name[idx]     = name;
      t_mode[idx]     = mode;
      t_nbeats[idx]   = nbeats;
      t_thr[idx]      = thr;
      t_nw[idx]       = nw;
      t_words[idx][0] = w0;
      t_words[idx][1] = w1;
      t_words[idx][2] = w2;
      t_rnd[idx]      = rnd_rdy;
      t_fill[idx]     = fill;
   endtask

   task automatic load_table();
      add_test(0, "cpu_12", MODE_CPU, 12, 0, 3,
               32'h4433_2211, 32'h8877_6655, 32'hccbb_aa99, 1'b0, 1'b0);
      add_test(1, "cpu_9_pad", MODE_CPU, 9, 0, 3,
               32'h1020_3040, 32'h5060_7080, 32'h90a0_b0c0, 1'b0, 1'b0);
      add_test(2, "cpu_12_rnd", MODE_CPU, 12, 0, 3,
               32'h4433_2211, 32'h8877_6655, 32'hccbb_aa99, 1'b1, 1'b0);
      add_test(3, "dma_12", MODE_DMA, 12, 0, 3,
               32'h4433_2211, 32'h8877_6655, 32'hccbb_aa99, 1'b0, 1'b0);
      add_test(4, "after_srst", MODE_CPU, 8, 2, 2,
               32'hdead_beef, 32'h0bad_f00d, 32'h0, 1'b0, 1'b1);
   endtask

   task automatic mismatch(input string what, input int exp, input int act);
      $display("MISMATCH %s: %s expected 0x%0h actual 0x%0h", cur_name, what, exp, act);
      errors++;
   endtask

   task automatic csr_write(input csr_addr_t addr, input logic [DATA_W-1:0] data,
                            input logic [3:0] strb);
      @(posedge clk);
      csr_wen   <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      csr_wstrb <= strb;
      @(posedge clk);
      csr_wen <= 1'b0;
   endtask

   task automatic expect_reg(input csr_addr_t addr, input int exp, input string what);
      logic [DATA_W-1:0] val;
      @(posedge clk);
      csr_addr <= addr;
      @(posedge clk);
      val = csr_rdata;
      if (val !== DATA_W'(exp)) begin
         mismatch(what, exp, int'(val));
      end
   endtask

   task automatic dma_send(input logic [DATA_W-1:0] word);
      @(posedge clk);
      sys_tvalid <= 1'b1;
      sys_tdata  <= word;
      @(posedge clk);
      while (!sys_tready) begin
         @(posedge clk);
      end
      sys_tvalid <= 1'b0;
   endtask

   // fills the FIFO under back-pressure, then overflows it by one word
   task automatic fill_and_overflow();
      int k;
      cur_name = "fifo_fill";
      rdy_sel <= 2;
      csr_write(A_ENABLE, 0, 4'hf);
      csr_write(A_SOFT_RESET, 1, 4'hf);
      csr_write(A_MODE, DATA_W'(MODE_CPU), 4'hf);
      csr_write(A_NWORDS, 100, 4'hf);
      csr_write(A_THRESHOLD, 2, 4'hf);
      csr_write(A_DATA, 32'h0101_0101, 4'hf);
      expect_reg(A_LEVEL, 0, "level while disabled");
      csr_write(A_ENABLE, 1, 4'hf);
      // first word moves on into the stream stage and stalls there
      csr_write(A_DATA, 32'h1000_0000, 4'hf);
      k = 0;
      while (tvalid !== 1'b1 && k < 50) begin
         @(posedge clk);
         k++;
      end
      if (tvalid !== 1'b1) begin
         $display("%s: no tvalid after the first word was written", cur_name);
         errors++;
      end
      expect_reg(A_LEVEL, 0, "level with word in stream stage");
      // stream stage is stalled, so an accepted word would stay in the FIFO
      csr_write(A_DATA, 32'h0202_0202, 4'h0);
      expect_reg(A_LEVEL, 0, "level after zero strobe write");
      for (k = 1; k <= FIFO_DEPTH; k++) begin
         csr_write(A_DATA, 32'h1000_0000 + k, 4'hf);
         expect_reg(A_LEVEL, k, "level during fill");
         if (irq !== (k <= 2)) begin
            mismatch("interrupt during fill", int'(k <= 2), int'(irq));
         end
      end
      expect_reg(A_STATUS, 1, "status when full");
      csr_write(A_DATA, 32'h2000_0000, 4'hf);
      expect_reg(A_LEVEL, FIFO_DEPTH, "level after write to full FIFO");
      if (sys_tready !== 1'b0) begin
         mismatch("sys_tready in CPU mode", 0, int'(sys_tready));
      end
   endtask

   task automatic run_frame(input int i);
      logic [TDATA_W:0] exp_q [$];
      int n;
      int b;
      int base;
      cur_name = t_name[i];
      mon_en  <= 1'b0;
      rdy_sel <= t_rnd[i] ? 1 : 0;
      csr_write(A_ENABLE, 0, 4'hf);
      csr_write(A_SOFT_RESET, 1, 4'hf);
      // soft reset leaves an empty FIFO, so the interrupt is up
      expect_reg(A_LEVEL, 0, "level after soft reset");
      expect_reg(A_STATUS, 2, "status after soft reset");
      if (irq !== 1'b1) begin
         mismatch("interrupt after soft reset", 1, int'(irq));
      end
      csr_write(A_MODE, DATA_W'(t_mode[i]), 4'hf);
      csr_write(A_NWORDS, t_nbeats[i], 4'hf);
      csr_write(A_THRESHOLD, t_thr[i], 4'hf);
      csr_write(A_ENABLE, 1, 4'hf);
      base = got_q.size();
      mon_en <= 1'b1;
      for (n = 0; n < t_nw[i]; n++) begin
         if (t_mode[i] == MODE_DMA) begin
            dma_send(t_words[i][n]);
         end else begin
            csr_write(A_DATA, t_words[i][n], 4'hf);
            if (sys_tready !== 1'b0) begin
               mismatch("sys_tready in CPU mode", 0, int'(sys_tready));
            end
         end
      end
      // LSB first, beats past nwords are padding and never seen
      for (b = 0; b < t_nw[i] * BEATS_PER_WORD; b++) begin
         if (b + 1 <= t_nbeats[i]) begin
            exp_q.push_back({(b + 1 == t_nbeats[i]),
               t_words[i][b / BEATS_PER_WORD][TDATA_W * (b % BEATS_PER_WORD) +: TDATA_W]});
         end
      end
      n = 0;
      while ((got_q.size() - base) < exp_q.size() && n < 200 * t_nw[i]) begin
         @(posedge clk);
         n++;
      end
      repeat (20) @(posedge clk);
      mon_en <= 1'b0;
      @(posedge clk);
      if ((got_q.size() - base) < exp_q.size()) begin
         $display("%s: %0d beats missing", cur_name, exp_q.size() - (got_q.size() - base));
         errors++;
      end
      if ((got_q.size() - base) > exp_q.size()) begin
         $display("%s: %0d extra beats", cur_name, (got_q.size() - base) - exp_q.size());
         errors++;
      end
      for (b = 0; b < exp_q.size() && b + base < got_q.size(); b++) begin
         if (got_q[b + base] !== exp_q[b]) begin
            mismatch($sformatf("beat %0d {tlast,tdata}", b + 1), int'(exp_q[b]),
                     int'(got_q[b + base]));
         end
      end
      expect_reg(A_LEVEL, 0, "level after frame");
   endtask

   initial begin
      int total;
      int limit;
      #1;
      total = 0;
      for (int j = 0; j < N_TESTS; j++) begin
         total += t_nw[j];
      end
      limit = 1000 + 200 * total;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      load_table();
      rst_n      = 1'b0;
      csr_wen    = 1'b0;
      csr_addr   = A_SOFT_RESET;
      csr_wdata  = '0;
      csr_wstrb  = '0;
      sys_tvalid = 1'b0;
      sys_tdata  = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      if ({tvalid, tlast, sys_tready, irq} !== 4'b0001) begin
         mismatch("tvalid,tlast,sys_tready,interrupt", 1,
                  int'({tvalid, tlast, sys_tready, irq}));
      end
      for (int i = 0; i < N_TESTS; i++) begin
         if (t_fill[i]) begin
            fill_and_overflow();
         end
         run_frame(i);
      end
      $display("run done: %0d check errors, %0d stall errors", errors, stall_errors);
      if (errors + stall_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/axis_out_cfg_pkg.sv ====
// ==========================================================================
// data path sizing and stream FSM states of the byte stream output block,
// imported by the RTL stages and by the testbench for state printing
// ==========================================================================

`default_nettype none

package axis_out_cfg_pkg;

   // word width on the CPU and DMA side
   localparam int DATA_W = 32;

   // beat width on the output stream
   localparam int TDATA_W = 8;

   // beats per FIFO word, least significant byte goes first
   localparam int BEATS_PER_WORD = DATA_W / TDATA_W;

   // word FIFO sizing
   localparam int FIFO_DEPTH  = 8;
   localparam int FIFO_ADDR_W = 3;
   // holds 0 up to FIFO_DEPTH
   localparam int LEVEL_W     = 4;

   // frame length register and beat counter
   localparam int CNT_W = 16;

   // output stage FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_SEND,
      ST_DROP
   } stream_state_t;

endpackage

`default_nettype wire

// ==== verilog/axis_out_csr_pkg.sv ====
// ==========================================================================
// register map and mode encoding of the control port, shared by the
// register stage and the testbench
// ==========================================================================

`default_nettype none

package axis_out_csr_pkg;

   // register addresses
   typedef enum logic [2:0] {
      // write 1 for a one-cycle soft reset
      A_SOFT_RESET = 3'd0,
      A_ENABLE     = 3'd1,
      A_MODE       = 3'd2,
      // frame length in beats
      A_NWORDS     = 3'd3,
      A_THRESHOLD  = 3'd4,
      // write only
      A_DATA       = 3'd5,
      // read only
      A_LEVEL      = 3'd6,
      // read only, bit 0 full and bit 1 empty
      A_STATUS     = 3'd7
   } csr_addr_t;

   // FIFO write source
   typedef enum logic {
      MODE_CPU = 1'b0,
      MODE_DMA = 1'b1
   } mode_t;

endpackage

`default_nettype wire

// ==== verilog/axis_out_fifo.sv ====
// ==========================================================================
// synchronous word FIFO between the register stage and the stream stage,
// with level and flags on the write interface and a registered read port
// ==========================================================================

`default_nettype none

module axis_out_fifo (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                soft_rst_i,
   axis_out_wr_if.sink                         wr,
   input  logic                                ren_i,
   output logic [axis_out_cfg_pkg::DATA_W-1:0] rdata_o,
   output logic                                empty_o
);
   import axis_out_cfg_pkg::*;

   logic [DATA_W-1:0]      mem [FIFO_DEPTH];
   logic [FIFO_ADDR_W-1:0] wptr_q;
   logic [FIFO_ADDR_W-1:0] rptr_q;
   logic [LEVEL_W-1:0]     level_q;
   logic                   full;
   logic                   empty;
   logic                   do_wr;
   logic                   do_rd;

   assign full  = (level_q == LEVEL_W'(FIFO_DEPTH));
   assign empty = (level_q == '0);

   // flags are also checked here, so a stray strobe cannot corrupt the level
   assign do_wr = wr.wen && !full;
   assign do_rd = ren_i && !empty;

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (do_wr) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_rd) begin
            rptr_q <= rptr_q + 1'b1;
         end
         // a write and a read together leave the level as it is
         case ({do_wr, do_rd})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // storage and read data register
   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wptr_q] <= wr.wdata;
      end
      if (do_rd) begin
         rdata_o <= mem[rptr_q];
      end
   end

   assign wr.full  = full;
   assign wr.empty = empty;
   assign wr.level = level_q;
   assign empty_o  = empty;

endmodule

`default_nettype wire

// ==== verilog/axis_out_regs.sv ====
// ==========================================================================
// control registers, FIFO write source selection (CPU or DMA), register
// read-back and the FIFO level interrupt
// ==========================================================================

`default_nettype none

module axis_out_regs (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                csr_wen_i,
   input  axis_out_csr_pkg::csr_addr_t         csr_addr_i,
   input  logic [axis_out_cfg_pkg::DATA_W-1:0] csr_wdata_i,
   input  logic [3:0]                          csr_wstrb_i,
   output logic [axis_out_cfg_pkg::DATA_W-1:0] csr_rdata_o,
   input  logic                                sys_tvalid_i,
   input  logic [axis_out_cfg_pkg::DATA_W-1:0] sys_tdata_i,
   output logic                                sys_tready_o,
   axis_out_wr_if.src                          wr,
   output logic                                soft_rst_o,
   output logic                                enable_o,
   output logic [axis_out_cfg_pkg::CNT_W-1:0]  nwords_o,
   output logic                                interrupt_o
);
   import axis_out_cfg_pkg::*;
   import axis_out_csr_pkg::*;

   logic               soft_rst_q;
   logic               enable_q;
   mode_t              mode_q;
   logic [CNT_W-1:0]   nwords_q;
   logic [LEVEL_W-1:0] threshold_q;
   logic               cpu_wen;
   logic               dma_wen;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         soft_rst_q  <= 1'b0;
         enable_q    <= 1'b0;
         mode_q      <= MODE_CPU;
         nwords_q    <= '0;
         threshold_q <= '0;
      end else begin
         // high for one cycle per write
         soft_rst_q <= csr_wen_i && (csr_addr_i == A_SOFT_RESET) && csr_wdata_i[0];
         if (csr_wen_i) begin
            case (csr_addr_i)
               A_ENABLE:    enable_q    <= csr_wdata_i[0];
               A_MODE:      mode_q      <= mode_t'(csr_wdata_i[0]);
               A_NWORDS:    nwords_q    <= csr_wdata_i[CNT_W-1:0];
               A_THRESHOLD: threshold_q <= csr_wdata_i[LEVEL_W-1:0];
               default:     ;
            endcase
         end
      end
   end

   // DMA side only takes words in DMA mode
   assign sys_tready_o = !wr.full && enable_q && (mode_q == MODE_DMA);
   assign dma_wen      = sys_tvalid_i && sys_tready_o;

   // CPU data writes are dropped unless every condition holds
   assign cpu_wen = csr_wen_i && (csr_addr_i == A_DATA) && (mode_q == MODE_CPU) &&
                    enable_q && !wr.full && (|csr_wstrb_i);

   // mode picks the source, so the two never mix in one cycle
   assign wr.wen   = cpu_wen || dma_wen;
   assign wr.wdata = (mode_q == MODE_DMA) ? sys_tdata_i : csr_wdata_i;

   // read-back, combinational from the address
   always_comb begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         A_ENABLE:    csr_rdata_o[0]           = enable_q;
         A_MODE:      csr_rdata_o[0]           = mode_q;
         A_NWORDS:    csr_rdata_o[CNT_W-1:0]   = nwords_q;
         A_THRESHOLD: csr_rdata_o[LEVEL_W-1:0] = threshold_q;
         A_LEVEL:     csr_rdata_o[LEVEL_W-1:0] = wr.level;
         A_STATUS:    csr_rdata_o[1:0]         = {wr.empty, wr.full};
         default:     csr_rdata_o              = '0;
      endcase
   end

   // asks for more data while the FIFO runs low
   assign interrupt_o = (wr.level <= threshold_q);

   assign soft_rst_o = soft_rst_q;
   assign enable_o   = enable_q;
   assign nwords_o   = nwords_q;

endmodule

`default_nettype wire

// ==== verilog/axis_out_stream.sv ====
// ==========================================================================
// output stage, splits FIFO words into byte beats (LSB first), counts beats
// for tlast and drops the padding beats past the programmed frame length
// ==========================================================================

`default_nettype none

module axis_out_stream (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 soft_rst_i,
   input  logic                                 enable_i,
   input  logic [axis_out_cfg_pkg::CNT_W-1:0]   nwords_i,
   output logic                                 fifo_ren_o,
   input  logic [axis_out_cfg_pkg::DATA_W-1:0]  fifo_rdata_i,
   input  logic                                 fifo_empty_i,
   output logic                                 axis_tvalid_o,
   output logic [axis_out_cfg_pkg::TDATA_W-1:0] axis_tdata_o,
   output logic                                 axis_tlast_o,
   input  logic                                 axis_tready_i
);
   import axis_out_cfg_pkg::*;

   stream_state_t                       state_q;
   stream_state_t                       state_d;
   logic [DATA_W-1:0]                   word_q;
   logic [TDATA_W-1:0]                  tdata_q;
   logic                                tlast_q;
   logic [$clog2(BEATS_PER_WORD)-1:0]   lane_q;
   logic [$clog2(BEATS_PER_WORD)-1:0]   lane_nxt;
   logic [CNT_W-1:0]                    cnt_q;
   logic [CNT_W:0]                      cur_beat;
   logic [CNT_W:0]                      nxt_beat;
   logic [CNT_W:0]                      nwords_ext;
   logic                                last_lane;
   logic                                consume;

   // cnt_q counts beats already gone, beat numbers start at 1
   assign cur_beat   = {1'b0, cnt_q} + 1'b1;
   assign nxt_beat   = {1'b0, cnt_q} + 2'd2;
   assign nwords_ext = {1'b0, nwords_i};
   assign lane_nxt   = lane_q + 1'b1;
   assign last_lane  = (int'(lane_q) == BEATS_PER_WORD - 1);

   always_comb begin
      state_d    = state_q;
      fifo_ren_o = 1'b0;
      consume    = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (enable_i && !fifo_empty_i) begin
               fifo_ren_o = 1'b1;
               state_d    = ST_FETCH;
            end
         end
         // read data is valid here and holds until the next read
         ST_FETCH: begin
            if (enable_i) begin
               state_d = (cur_beat <= nwords_ext) ? ST_SEND : ST_DROP;
            end
         end
         ST_SEND, ST_DROP: begin
            // padding goes one beat per cycle, no tready needed
            consume = enable_i && ((state_q == ST_DROP) || axis_tready_i);
            if (consume) begin
               if (last_lane) begin
                  if (fifo_empty_i) begin
                     state_d = ST_IDLE;
                  end else begin
                     fifo_ren_o = 1'b1;
                     state_d    = ST_FETCH;
                  end
               end else if (nxt_beat > nwords_ext) begin
                  state_d = ST_DROP;
               end
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || soft_rst_i) begin
         state_q <= ST_IDLE;
         lane_q  <= '0;
         cnt_q   <= '0;
         tlast_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (consume) begin
            lane_q <= lane_nxt;
            // saturates, so a long padding run never reopens the frame
            if (!(&cnt_q)) begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
         if ((state_q == ST_FETCH) && enable_i) begin
            tlast_q <= (cur_beat == nwords_ext);
         end else if (consume && !last_lane) begin
            tlast_q <= (nxt_beat == nwords_ext);
         end
      end
   end

   // word holding register and beat output register
   always_ff @(posedge clk_i) begin
      if ((state_q == ST_FETCH) && enable_i) begin
         word_q  <= fifo_rdata_i;
         tdata_q <= fifo_rdata_i[TDATA_W-1:0];
      end else if (consume && !last_lane) begin
         tdata_q <= word_q[lane_nxt*TDATA_W +: TDATA_W];
      end
   end

   // data and last only move on a transfer, so they hold while stalled
   assign axis_tvalid_o = (state_q == ST_SEND) && enable_i;
   assign axis_tdata_o  = tdata_q;
   assign axis_tlast_o  = axis_tvalid_o && tlast_q;

endmodule

`default_nettype wire

// ==== verilog/axis_out_top.sv ====
// ==========================================================================
// byte stream output peripheral, register port and DMA input in, byte
// stream and FIFO level interrupt out
// ==========================================================================

`default_nettype none

module axis_out_top (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 csr_wen_i,
   input  axis_out_csr_pkg::csr_addr_t          csr_addr_i,
   input  logic [axis_out_cfg_pkg::DATA_W-1:0]  csr_wdata_i,
   input  logic [3:0]                           csr_wstrb_i,
   output logic [axis_out_cfg_pkg::DATA_W-1:0]  csr_rdata_o,
   input  logic                                 sys_tvalid_i,
   input  logic [axis_out_cfg_pkg::DATA_W-1:0]  sys_tdata_i,
   output logic                                 sys_tready_o,
   output logic                                 axis_tvalid_o,
   output logic [axis_out_cfg_pkg::TDATA_W-1:0] axis_tdata_o,
   output logic                                 axis_tlast_o,
   input  logic                                 axis_tready_i,
   output logic                                 interrupt_o
);
   import axis_out_cfg_pkg::*;

   logic              soft_rst;
   logic              enable;
   logic [CNT_W-1:0]  nwords;
   logic              fifo_ren;
   logic [DATA_W-1:0] fifo_rdata;
   logic              fifo_empty;

   axis_out_wr_if i_wr_if ();

   axis_out_regs i_regs (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .csr_wen_i    (csr_wen_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_wstrb_i  (csr_wstrb_i),
      .csr_rdata_o  (csr_rdata_o),
      .sys_tvalid_i (sys_tvalid_i),
      .sys_tdata_i  (sys_tdata_i),
      .sys_tready_o (sys_tready_o),
      .wr           (i_wr_if.src),
      .soft_rst_o   (soft_rst),
      .enable_o     (enable),
      .nwords_o     (nwords),
      .interrupt_o  (interrupt_o)
   );

   axis_out_fifo i_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .soft_rst_i (soft_rst),
      .wr         (i_wr_if.sink),
      .ren_i      (fifo_ren),
      .rdata_o    (fifo_rdata),
      .empty_o    (fifo_empty)
   );

   axis_out_stream i_stream (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .soft_rst_i    (soft_rst),
      .enable_i      (enable),
      .nwords_i      (nwords),
      .fifo_ren_o    (fifo_ren),
      .fifo_rdata_i  (fifo_rdata),
      .fifo_empty_i  (fifo_empty),
      .axis_tvalid_o (axis_tvalid_o),
      .axis_tdata_o  (axis_tdata_o),
      .axis_tlast_o  (axis_tlast_o),
      .axis_tready_i (axis_tready_i)
   );

endmodule

`default_nettype wire

// ==== verilog/axis_out_wr_if.sv ====
// ==========================================================================
// word write path from the register stage into the FIFO, with the FIFO
// flags and level coming back for flow control, read-back and interrupt
// ==========================================================================

`default_nettype none

interface axis_out_wr_if;
   import axis_out_cfg_pkg::*;

   logic               wen;
   logic [DATA_W-1:0]  wdata;
   logic               full;
   logic               empty;
   logic [LEVEL_W-1:0] level;

   // register stage side
   modport src (
      output wen,
      output wdata,
      input  full,
      input  empty,
      input  level
   );

   // FIFO side
   modport sink (
      input  wen,
      input  wdata,
      output full,
      output empty,
      output level
   );

endinterface

`default_nettype wire
